/* verilog.f */
+incdir+verilog
verilog/lc3b_types.sv
verilog/regfile_if.sv
verilog/pipe_reg.sv
verilog/regfile.sv
verilog/alu.sv
verilog/control.sv
verilog/datapath.sv
verilog/mp3.sv
sim/mp3_assertions.sv
sim/tb_mp3.sv

/* sim/tb_mp3.sv */
`timescale 1ns/100ps

module tb_mp3 import lc3b_types::*; ();

    localparam int       clk_half      = 20;        // Half of the 40 ns period.
    localparam int       drive_delay   = 2;         // Inputs move this long after the edge.
    localparam int       store_timeout = 20000;     // Cycles allowed for all stores.
    localparam int       drain_cycles  = 40;        // Quiet cycles after the last store.
    localparam lc3b_word data_base     = 16'h0100;  // Byte address of the load data.
    localparam lc3b_word store_base    = 16'h0180;  // Byte address of the register dump.

    logic     clk;
    logic     rst;
    logic     mem_resp;
    lc3b_word mem_rdata;
    logic     mem_read;
    logic     mem_write;
    lc3b_word mem_address;
    lc3b_word mem_wdata;
    logic     instr_resp;
    lc3b_word instr_rdata;
    logic     instr_read;
    logic     instr_write;
    lc3b_word instr_address;
    lc3b_word instr_wdata;

    lc3b_word mem [65536];        // One word array behind both ports.
    lc3b_word model_mem [65536];  // The ISA model works on its own copy.
    lc3b_word exp_addr [$];       // Stores in program order.
    lc3b_word exp_data [$];
    int       exp_count;
    int       stores_seen;
    int       gen_pc;             // Word index of the next instruction to emit.
    int       instr_wait;         // Cycles left before the next fetch answer.
    int       data_wait;

    mp3 dut_i (
        .clk(clk), .rst(rst),
        .mem_resp(mem_resp), .mem_rdata(mem_rdata),
        .mem_read(mem_read), .mem_write(mem_write),
        .mem_address(mem_address), .mem_wdata(mem_wdata),
        .instr_resp(instr_resp), .instr_rdata(instr_rdata),
        .instr_read(instr_read), .instr_write(instr_write),
        .instr_address(instr_address), .instr_wdata(instr_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_half) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Checking helpers.
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic fail_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input lc3b_word got,
                                input lc3b_word expected);
        if (got !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            fail_run();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Program generator.
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic emit(input lc3b_word instr);
        mem[gen_pc] = instr;
        gen_pc++;
    endtask

    // PCoffset9 from the instruction about to be emitted to a byte target.
    function automatic logic [8:0] pc_offset9(input int target_byte);
        int delta;
        delta = (target_byte - (gen_pc * 2 + 2)) / 2;
        return delta[8:0];
    endfunction

    task automatic build_program();
        int      loop_byte;
        lc3b_reg dr;
        lc3b_reg sa;
        lc3b_reg sb;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = {i[7:0], i[15:8]} ^ 16'ha5c3;   // Each word differs with its address.
        end
        mem[data_base[15:1]]     = 16'h7ff3;   // Positive load value.
        mem[data_base[15:1] + 1] = 16'h8c35;   // Negative load value.
        gen_pc = 0;
        emit({4'b1110, 3'd6, pc_offset9(data_base)});   // LEA R6 to the load data.
        emit({4'b0110, 3'd1, 3'd6, 6'd0});             // LDR R1, R6, #0.
        emit({4'b0001, 3'd2, 3'd1, 3'b000, 3'd1});     // ADD R2, R1, R1 is a load use.
        emit({4'b0110, 3'd3, 3'd6, 6'd1});             // LDR R3, R6, #1.
        emit({4'b0101, 3'd4, 3'd3, 3'b000, 3'd2});     // AND R4, R3, R2.
        emit({4'b1001, 3'd5, 3'd4, 6'h3f});            // NOT R5, R4.
        emit({4'b0001, 3'd5, 3'd5, 1'b1, 5'd1});       // ADD R5, R5, #1.
        emit({4'b0111, 3'd5, 3'd6, 6'd2});             // STR R5 right behind its producer.
        emit({4'b0110, 3'd0, 3'd6, 6'd2});             // LDR R0 reads that word back.
        emit({4'b0101, 3'd7, 3'd7, 1'b1, 5'd0});       // Clear the loop counter.
        emit({4'b0001, 3'd7, 3'd7, 1'b1, 5'd5});       // Five passes.
        loop_byte = gen_pc * 2;
        emit({4'b0001, 3'd1, 3'd1, 3'b000, 3'd0});     // ADD R1, R1, R0.
        emit({4'b0111, 3'd1, 3'd6, 6'd3});             // One store per pass.
        emit({4'b0001, 3'd7, 3'd7, 1'b1, 5'h1f});      // Count down.
        emit({4'b0000, 3'b001, pc_offset9(loop_byte)}); // BRp back to the loop.
        emit({4'b0000, 3'b111, pc_offset9(gen_pc * 2 + 4)});
        emit({4'b0111, 3'd2, 3'd6, 6'd4});             // Skipped, so it must never store.
        // Random ALU and LEA mix.
        for (int k = 0; k < 24; k++) begin
            dr = 3'($urandom);
            sa = 3'($urandom);
            sb = 3'($urandom);
            case ($urandom % 6)
                0: emit({4'b0001, dr, sa, 3'b000, sb});
                1: emit({4'b0001, dr, sa, 1'b1, 5'($urandom)});
                2: emit({4'b0101, dr, sa, 3'b000, sb});
                3: emit({4'b0101, dr, sa, 1'b1, 5'($urandom)});
                4: emit({4'b1001, dr, sa, 6'h3f});
                default: emit({4'b1110, dr, 9'($urandom)});
            endcase
        end
        emit({4'b1110, 3'd6, pc_offset9(store_base)}); // R6 to the dump region.
        for (int k = 0; k < 8; k++) begin
            emit({4'b0111, 3'(k), 3'd6, 6'(k)});       // STR Rk, R6, #k.
        end
        emit({4'b0000, 3'b111, 9'h1ff});               // Branch to itself.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // ISA reference model.
    // ~~~~~~~~~~~~~~~~~~~~

    // Runs the image one instruction at a time and fills exp_addr and exp_data.
    // It returns the store count, or -1 when the final self branch is never hit.
    function automatic int model_stores();
        lc3b_word r [8];
        lc3b_word pc;
        lc3b_word npc;
        lc3b_word ir;
        lc3b_word res;
        lc3b_word addr;
        lc3b_word imm;
        lc3b_word off9;
        lc3b_nzp  cc;
        logic     wr;
        for (int i = 0; i < 8; i++) begin
            r[i] = '0;
        end
        pc = 16'h0000;
        cc = 3'b010;   // Zero registers give Z.
        for (int step = 0; step < 5000; step++) begin
            ir   = model_mem[pc[15:1]];
            npc  = pc + 16'd2;
            imm  = {{11{ir[4]}}, ir[4:0]};
            off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
            addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
            res  = '0;
            wr   = 1'b0;
            case (ir[15:12])
                4'b0001: begin
                    res = r[ir[8:6]] + (ir[5] ? imm : r[ir[2:0]]);
                    wr  = 1'b1;
                end
                4'b0101: begin
                    res = r[ir[8:6]] & (ir[5] ? imm : r[ir[2:0]]);
                    wr  = 1'b1;
                end
                4'b1001: begin
                    res = ~r[ir[8:6]];
                    wr  = 1'b1;
                end
                4'b0110: begin
                    res = model_mem[addr[15:1]];
                    wr  = 1'b1;
                end
                4'b0111: begin
                    model_mem[addr[15:1]] = r[ir[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[ir[11:9]]);
                end
                4'b1110: begin
                    r[ir[11:9]] = npc + off9;   // No condition code update.
                end
                4'b0000: begin
                    if ((ir[11:9] & cc) != 3'b000) begin
                        if (npc + off9 == pc) begin
                            return exp_addr.size();   // End of the program.
                        end
                        npc = npc + off9;
                    end
                end
                default: begin
                end
            endcase
            if (wr) begin
                r[ir[11:9]] = res;
                cc = res[15] ? 3'b100 : ((res == 16'h0000) ? 3'b010 : 3'b001);
            end
            pc = npc;
        end
        return -1;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Memory model.
    // ~~~~~~~~~~~~~~~~~~~~

    // The fetch port always has a request, so it answers every few cycles.
    always @(posedge clk) begin
        logic in_reset;
        in_reset = rst;   // Reset as the DUT sees it on this edge.
        #(drive_delay);
        if (in_reset) begin
            instr_resp = 1'b0;
        end else if (instr_wait == 0) begin
            instr_resp  = 1'b1;
            instr_rdata = mem[instr_address[15:1]];
            instr_wait  = $urandom % 4;   // Wait for the next fetch.
        end else begin
            instr_resp = 1'b0;
            instr_wait--;
        end
    end

    always @(posedge clk) begin
        logic in_reset;
        in_reset = rst;
        #(drive_delay);
        mem_resp = 1'b0;
        if (!in_reset && (mem_read || mem_write)) begin
            if (data_wait == 0) begin
                mem_resp = 1'b1;
                if (mem_write) begin
                    mem[mem_address[15:1]] = mem_wdata;
                end else begin
                    mem_rdata = mem[mem_address[15:1]];
                end
                data_wait = $urandom % 4;
            end else begin
                data_wait--;
            end
        end
    end

    // Stores are taken mid-cycle, where the request and mem_resp are settled.
    always @(negedge clk) begin
        if (dut_i.mp3_assertions_i.fail_count != 0) begin
            $display("a memory port protocol assertion failed");
            fail_run();
        end else if (!rst && mem_resp && mem_write) begin
            if (stores_seen >= exp_count) begin
                $display("store to address %h beyond the expected sequence", mem_address);
                fail_run();
            end else begin
                compare_word("mem_address", mem_address, exp_addr[stores_seen]);
                compare_word("mem_wdata", mem_wdata, exp_data[stores_seen]);
                stores_seen++;
            end
        end
    end

    initial begin
        int cycles;
        rst         = 1'b1;
        mem_resp    = 1'b0;
        mem_rdata   = '0;
        instr_resp  = 1'b0;
        instr_rdata = '0;
        stores_seen = 0;
        exp_count   = 0;
        void'($urandom(32'h2221));
        instr_wait = $urandom % 4;
        data_wait  = $urandom % 4;
        build_program();
        model_mem = mem;
        exp_count = model_stores();
        if (exp_count <= 0) begin
            $display("reference model never reached the final self branch");
            fail_run();
        end
        repeat (5) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;
        compare_word("mem_read", 16'(mem_read), 16'h0000);
        compare_word("mem_write", 16'(mem_write), 16'h0000);
        compare_word("instr_address", instr_address, 16'h0000);
        compare_word("instr_read", 16'(instr_read), 16'h0001);   // Fetch never pauses.
        compare_word("instr_write", 16'(instr_write), 16'h0000);
        compare_word("instr_wdata", instr_wdata, 16'h0000);
        cycles = 0;
        while (stores_seen < exp_count) begin
            @(posedge clk);
            cycles++;
            if (cycles > store_timeout) begin
                $display("timeout after %0d cycles with %0d of %0d stores seen",
                         cycles, stores_seen, exp_count);
                fail_run();
            end
        end
        repeat (drain_cycles) @(posedge clk);   // No further store may show up.
        $display("** PASS **");
        $finish;
    end

endmodule : tb_mp3

/* sim/mp3_assertions.sv */
`timescale 1ns/100ps

module mp3_assertions import lc3b_types::*; (
    input logic     clk,
    input logic     rst,
    input logic     mem_resp,
    input logic     mem_read,
    input logic     mem_write,
    input lc3b_word mem_address,
    input lc3b_word mem_wdata,
    input logic     instr_resp,
    input lc3b_word instr_address
);

    int unsigned fail_count = 0;   // Bumped by every failing assertion below.

    // A data request is either a read or a write, never both.
    strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write high together");
            fail_count++;
        end

    // The cycle after a reset edge has no data request at all.
    strobes_low_in_reset: assert property (@(posedge clk)
        rst |=> (!mem_read && !mem_write))
        else begin
            $error("data strobe high during reset");
            fail_count++;
        end

    // A waiting data request holds everything until mem_resp.
    data_request_stable: assert property (@(posedge clk) disable iff (rst)
        ((mem_read || mem_write) && !mem_resp) |=>
        ($stable(mem_read) && $stable(mem_write) &&
         $stable(mem_address) && $stable(mem_wdata)))
        else begin
            $error("data request changed while waiting");
            fail_count++;
        end

    // The fetch address only moves on an instr_resp edge.
    fetch_address_stable: assert property (@(posedge clk) disable iff (rst)
        !instr_resp |=> $stable(instr_address))
        else begin
            $error("instr_address changed while waiting");
            fail_count++;
        end

endmodule : mp3_assertions

bind mp3 mp3_assertions mp3_assertions_i (
    .clk(clk), .rst(rst), .mem_resp(mem_resp), .mem_read(mem_read),
    .mem_write(mem_write), .mem_address(mem_address), .mem_wdata(mem_wdata),
    .instr_resp(instr_resp), .instr_address(instr_address)
);

/* verilog/mp3.sv */
`timescale 1ns/100ps

module mp3 import lc3b_types::*; (
    input  logic     clk,
    input  logic     rst,

    // Data port.
    input  logic     mem_resp,
    input  lc3b_word mem_rdata,
    output logic     mem_read,
    output logic     mem_write,
    output lc3b_word mem_address,
    output lc3b_word mem_wdata,

    // Read-only instruction port.
    input  logic     instr_resp,
    input  lc3b_word instr_rdata,
    output logic     instr_read,
    output logic     instr_write,
    output lc3b_word instr_address,
    output lc3b_word instr_wdata
);

    lc3b_ctrl_word ctrl;
    lc3b_word      ir;
    lc3b_aluop     aluop;
    lc3b_word      alu_a;
    lc3b_word      alu_b;
    lc3b_word      alu_f;

    regfile_if rf_bus ();

    // Fetch reads every cycle and never writes.
    assign instr_read  = 1'b1;
    assign instr_write = 1'b0;
    assign instr_wdata = '0;

    datapath datapath_i (
        .clk(clk), .rst(rst), .ctrl(ctrl), .ir(ir), .rf(rf_bus.client),
        .aluop(aluop), .alu_a(alu_a), .alu_b(alu_b), .alu_f(alu_f),
        .mem_resp(mem_resp), .mem_rdata(mem_rdata),
        .mem_read(mem_read), .mem_write(mem_write),
        .mem_address(mem_address), .mem_wdata(mem_wdata),
        .instr_resp(instr_resp), .instr_rdata(instr_rdata),
        .instr_address(instr_address)
    );

    control control_i (
        .ir(ir),
        .ctrl(ctrl)
    );

    regfile regfile_i (
        .clk(clk),
        .rst(rst),
        .rf(rf_bus.server)
    );

    alu alu_i (
        .aluop(aluop),
        .a(alu_a),
        .b(alu_b),
        .f(alu_f)
    );

endmodule : mp3

/* verilog/datapath.sv */
`timescale 1ns/100ps
`include "lc3b_consts.svh"

module datapath import lc3b_types::*; (
    input  logic          clk,
    input  logic          rst,
    input  lc3b_ctrl_word ctrl,       // Decoded from ir by control.
    output lc3b_word      ir,
    regfile_if.client     rf,
    output lc3b_aluop     aluop,
    output lc3b_word      alu_a,
    output lc3b_word      alu_b,
    input  lc3b_word      alu_f,
    input  logic          mem_resp,
    input  lc3b_word      mem_rdata,
    output logic          mem_read,
    output logic          mem_write,
    output lc3b_word      mem_address,
    output lc3b_word      mem_wdata,
    input  logic          instr_resp,
    input  lc3b_word      instr_rdata,
    output lc3b_word      instr_address
);

    lc3b_word pc;
    lc3b_word pc_plus2;
    lc3b_word redirect_pc;       // Target waiting for the fetch in flight.
    logic     redirect_pending;  // A taken branch arrived mid-fetch.
    lc3b_nzp  cc;
    lc3b_nzp  wb_cc;

    if_id_t  if_id_d, if_id_q;
    id_ex_t  id_ex_d, id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;
    logic    if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid;

    logic     freeze;     // Memory stage waits, everything holds.
    logic     id_stall;   // Decode waits on a hazard.
    logic     if_stall;
    logic     use_a, use_b;
    logic     hz_ex, hz_mem, hz_cc;
    lc3b_reg  src_a, src_b;
    lc3b_word dec_offset;
    lc3b_word br_target;
    logic     br_taken;
    logic     redirect;

    assign freeze   = (mem_read || mem_write) && !mem_resp;
    assign if_stall = freeze || id_stall;
    assign redirect = br_taken && !freeze;

    // ~~~~~~~~~~~~~~~~~~~~
    // Fetch.
    // ~~~~~~~~~~~~~~~~~~~~

    assign instr_address = pc;   // Only changes on an instr_resp edge.
    assign pc_plus2      = pc + 16'd2;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc               <= `LC3B_RESET_PC;
            redirect_pending <= 1'b0;
        end else if (redirect && !instr_resp) begin
            redirect_pending <= 1'b1;   // Let the current fetch finish first.
            redirect_pc      <= br_target;
        end else if (instr_resp) begin
            redirect_pending <= 1'b0;
            if (redirect) begin
                pc <= br_target;
            end else if (redirect_pending) begin
                pc <= redirect_pc;      // The word just fetched is dropped.
            end else if (!if_stall) begin
                pc <= pc_plus2;
            end
            // A stalled fetch keeps pc and reads the same word again.
        end
    end

    always_comb begin
        if_id_d.pc_plus2 = pc_plus2;
        if_id_d.instr    = instr_rdata;
    end

    pipe_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk(clk), .rst(rst), .stall(if_stall), .flush(redirect),
        .valid_in(instr_resp && !redirect_pending),
        .d(if_id_d), .valid(if_id_valid), .q(if_id_q)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Decode and hazards.
    // ~~~~~~~~~~~~~~~~~~~~

    assign ir    = if_id_q.instr;
    assign src_a = ir[8:6];                                // SR1 or BaseR.
    assign src_b = ctrl.mem_write ? ir[11:9] : ir[2:0];    // STR reads SR here.
    assign use_a = (ctrl.reg_write && !ctrl.lea) || ctrl.mem_write;
    assign use_b = (ctrl.reg_write && !ctrl.imm_sel && !ctrl.lea &&
                    (ctrl.aluop != alu_not)) || ctrl.mem_write;

    assign rf.idx_a = src_a;
    assign rf.idx_b = src_b;

    // Writeback needs no check because the register file bypass covers it.
    assign hz_ex  = id_ex_valid && id_ex_q.ctrl.reg_write &&
                    ((use_a && (id_ex_q.dest == src_a)) ||
                     (use_b && (id_ex_q.dest == src_b)));
    assign hz_mem = ex_mem_valid && ex_mem_q.ctrl.reg_write &&
                    ((use_a && (ex_mem_q.dest == src_a)) ||
                     (use_b && (ex_mem_q.dest == src_b)));
    assign hz_cc  = ctrl.branch &&
                    ((id_ex_valid && id_ex_q.ctrl.set_cc) ||
                     (ex_mem_valid && ex_mem_q.ctrl.set_cc));
    assign id_stall = if_id_valid && (hz_ex || hz_mem || hz_cc);

    always_comb begin
        if (ctrl.mem_read || ctrl.mem_write) begin
            dec_offset = {{9{ir[5]}}, ir[5:0], 1'b0};   // Offset6 scaled to words.
        end else if (ctrl.imm_sel) begin
            dec_offset = {{11{ir[4]}}, ir[4:0]};        // imm5.
        end else begin
            dec_offset = {{6{ir[8]}}, ir[8:0], 1'b0};   // PCoffset9 for BR, LEA.
        end
        id_ex_d.ctrl     = ctrl;
        id_ex_d.a        = rf.data_a;
        id_ex_d.b        = rf.data_b;
        id_ex_d.offset   = dec_offset;
        id_ex_d.dest     = ir[11:9];   // DR, or the nzp mask of a BR.
        id_ex_d.pc_plus2 = if_id_q.pc_plus2;
    end

    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk(clk), .rst(rst), .stall(freeze), .flush(redirect),
        .valid_in(if_id_valid && !id_stall),   // Bubble while decode waits.
        .d(id_ex_d), .valid(id_ex_valid), .q(id_ex_q)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Execute.
    // ~~~~~~~~~~~~~~~~~~~~

    assign br_target = id_ex_q.pc_plus2 + id_ex_q.offset;
    assign br_taken  = id_ex_valid && id_ex_q.ctrl.branch &&
                       ((id_ex_q.dest & cc) != 3'b000);

    assign aluop = id_ex_q.ctrl.aluop;
    assign alu_a = id_ex_q.a;
    assign alu_b = id_ex_q.ctrl.lea     ? br_target :
                   id_ex_q.ctrl.imm_sel ? id_ex_q.offset : id_ex_q.b;

    always_comb begin
        ex_mem_d.ctrl       = id_ex_q.ctrl;
        ex_mem_d.alu_out    = alu_f;
        ex_mem_d.store_data = id_ex_q.b;
        ex_mem_d.dest       = id_ex_q.dest;
    end

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk(clk), .rst(rst), .stall(freeze), .flush(1'b0),
        .valid_in(id_ex_valid),
        .d(ex_mem_d), .valid(ex_mem_valid), .q(ex_mem_q)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Memory and writeback.
    // ~~~~~~~~~~~~~~~~~~~~

    // Held steady by the freeze until mem_resp closes the transfer.
    assign mem_read    = ex_mem_valid && ex_mem_q.ctrl.mem_read;
    assign mem_write   = ex_mem_valid && ex_mem_q.ctrl.mem_write;
    assign mem_address = ex_mem_q.alu_out;
    assign mem_wdata   = ex_mem_q.store_data;

    always_comb begin
        mem_wb_d.reg_write = ex_mem_q.ctrl.reg_write;
        mem_wb_d.set_cc    = ex_mem_q.ctrl.set_cc;
        mem_wb_d.dest      = ex_mem_q.dest;
        mem_wb_d.result    = ex_mem_q.ctrl.mem_read ? mem_rdata : ex_mem_q.alu_out;
    end

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk(clk), .rst(rst), .stall(freeze), .flush(1'b0),
        .valid_in(ex_mem_valid),
        .d(mem_wb_d), .valid(mem_wb_valid), .q(mem_wb_q)
    );

    assign rf.we    = mem_wb_valid && mem_wb_q.reg_write;
    assign rf.widx  = mem_wb_q.dest;
    assign rf.wdata = mem_wb_q.result;

    always_comb begin
        if (mem_wb_q.result[15]) begin
            wb_cc = 3'b100;
        end else if (mem_wb_q.result == 16'h0000) begin
            wb_cc = 3'b010;
        end else begin
            wb_cc = 3'b001;
        end
    end

    // Registers reset to zero, so the code starts out as Z.
    always_ff @(posedge clk) begin
        if (rst) begin
            cc <= 3'b010;
        end else if (mem_wb_valid && mem_wb_q.set_cc) begin
            cc <= wb_cc;
        end
    end

endmodule : datapath

/* verilog/control.sv */
`timescale 1ns/100ps
`include "lc3b_consts.svh"

module control import lc3b_types::*; (
    input  lc3b_word      ir,
    output lc3b_ctrl_word ctrl
);

    lc3b_opcode opcode;

    assign opcode = lc3b_opcode'(ir[`LC3B_OP_MSB:`LC3B_OP_LSB]);

    always_comb begin
        // Start from a word that does nothing at all.
        ctrl.aluop     = alu_add;
        ctrl.imm_sel   = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.set_cc    = 1'b0;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.lea       = 1'b0;

        case (opcode)
            op_add: begin
                ctrl.aluop     = alu_add;
                ctrl.imm_sel   = ir[`LC3B_IMM_BIT];   // imm5 or SR2.
                ctrl.reg_write = 1'b1;
                ctrl.set_cc    = 1'b1;
            end
            op_and: begin
                ctrl.aluop     = alu_and;
                ctrl.imm_sel   = ir[`LC3B_IMM_BIT];
                ctrl.reg_write = 1'b1;
                ctrl.set_cc    = 1'b1;
            end
            op_not: begin
                ctrl.aluop     = alu_not;
                ctrl.reg_write = 1'b1;
                ctrl.set_cc    = 1'b1;
            end
            op_br: begin
                ctrl.branch    = 1'b1;   // Taken or not is decided in execute.
            end
            op_ldr: begin
                ctrl.aluop     = alu_add;   // BaseR plus scaled offset6.
                ctrl.imm_sel   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.set_cc    = 1'b1;
            end
            op_str: begin
                ctrl.aluop     = alu_add;
                ctrl.imm_sel   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_lea: begin
                // LC-3b LEA leaves the condition code alone.
                ctrl.aluop     = alu_pass;
                ctrl.lea       = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: begin
                // Anything else flows through as a bubble with no effect.
            end
        endcase
    end

endmodule : control

/* verilog/alu.sv */
`timescale 1ns/100ps

module alu import lc3b_types::*; (
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    always_comb begin
        case (aluop)
            alu_add: begin
                f = a + b;   // ADD, and base plus offset for LDR and STR.
            end
            alu_and: begin
                f = a & b;
            end
            alu_not: begin
                f = ~a;      // NOT ignores operand b.
            end
            alu_pass: begin
                f = b;       // LEA hands its address through here.
            end
            default: begin
                f = b;
            end
        endcase
    end

endmodule : alu

/* verilog/regfile.sv */
`timescale 1ns/100ps
`include "lc3b_consts.svh"

module regfile import lc3b_types::*; (
    input logic       clk,
    input logic       rst,
    regfile_if.server rf
);

    lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;   // All registers start at zero.
            end
        end else if (rf.we) begin
            regs[rf.widx] <= rf.wdata;
        end
    end

    // A read of the register being written this cycle sees the new value.
    // This lets decode read a result in the same cycle it retires.
    always_comb begin
        rf.data_a = regs[rf.idx_a];
        if (rf.we && (rf.widx == rf.idx_a)) begin
            rf.data_a = rf.wdata;
        end
        rf.data_b = regs[rf.idx_b];
        if (rf.we && (rf.widx == rf.idx_b)) begin
            rf.data_b = rf.wdata;
        end
    end

endmodule : regfile

/* verilog/pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,      // Hold the current contents.
    input  logic     flush,      // Turn the stage into a bubble.
    input  logic     valid_in,
    input  payload_t d,
    output logic     valid,
    output payload_t q
);

    // Flush beats stall, so a taken branch can kill a stalled stage.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            q <= d;   // The payload moves along with its valid bit.
        end
    end

endmodule : pipe_reg

/* verilog/regfile_if.sv */
`timescale 1ns/100ps

// Two read ports and one write port of the register file.
interface regfile_if import lc3b_types::*; ();

    lc3b_reg  idx_a;    // Read port a index.
    lc3b_word data_a;   // Read port a data.
    lc3b_reg  idx_b;    // Read port b index.
    lc3b_word data_b;   // Read port b data.
    logic     we;       // Write enable from writeback.
    lc3b_reg  widx;     // Write index.
    lc3b_word wdata;    // Write data.

    // The datapath asks for operands and retires results.
    modport client (output idx_a, idx_b, we, widx, wdata,
                    input  data_a, data_b);

    // The register file answers reads and takes writes.
    modport server (input  idx_a, idx_b, we, widx, wdata,
                    output data_a, data_b);

endinterface : regfile_if

/* verilog/lc3b_types.sv */
package lc3b_types;

    typedef logic [15:0] lc3b_word;   // Data and address values.
    typedef logic [2:0]  lc3b_reg;    // Register index.
    typedef logic [2:0]  lc3b_nzp;    // Condition code, n in bit 2.

    // Full LC-3b opcode map. Only part of it is executed by this core.
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // Control word produced in decode and carried down the pipe.
    typedef struct packed {
        lc3b_aluop aluop;       // Operation for the execute stage.
        logic      imm_sel;     // ALU operand b comes from the offset field.
        logic      reg_write;   // Writes DR in writeback.
        logic      set_cc;      // Updates the condition code in writeback.
        logic      mem_read;    // LDR.
        logic      mem_write;   // STR.
        logic      branch;      // The nzp mask of a BR rides in the dest field.
        logic      lea;         // ALU passes the PC-relative address.
    } lc3b_ctrl_word;

    typedef struct packed {
        lc3b_word pc_plus2;
        lc3b_word instr;
    } if_id_t;

    typedef struct packed {
        lc3b_ctrl_word ctrl;
        lc3b_word      a;          // SR1 or BaseR.
        lc3b_word      b;          // SR2, or the store source for STR.
        lc3b_word      offset;     // Sign-extended and already scaled.
        lc3b_reg       dest;
        lc3b_word      pc_plus2;
    } id_ex_t;

    typedef struct packed {
        lc3b_ctrl_word ctrl;
        lc3b_word      alu_out;    // Result, or the address for LDR and STR.
        lc3b_word      store_data;
        lc3b_reg       dest;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        logic     set_cc;
        lc3b_reg  dest;
        lc3b_word result;
    } mem_wb_t;

endpackage : lc3b_types

/* verilog/lc3b_consts.svh */
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// Fetch starts here when rst is released.
`define LC3B_RESET_PC 16'h0000

// Depth of the architectural register file (R0 to R7).
`define LC3B_NUM_REGS 8

// ~~~~~~~~~~~~~~~~~~~~
// Instruction field positions.
// ~~~~~~~~~~~~~~~~~~~~

`define LC3B_OP_MSB 15   // Top bit of the opcode field.
`define LC3B_OP_LSB 12   // Bottom bit of the opcode field.

// Bit 5 picks imm5 over SR2 in ADD and AND.
`define LC3B_IMM_BIT 5

`endif
